/* common/shm_config.svh */
`ifndef SHM_CONFIG_SVH
`define SHM_CONFIG_SVH

// number of banks, kept a power of two so the bank field decodes cleanly
`define SHM_NUM_BANKS 4

// lines held by each bank
`define SHM_BANK_HEIGHT 128

// 32-bit words in one bank line
`define SHM_WORDS_PER_LINE 4

// width of the byte address on the request side
`define SHM_ADDR_WIDTH 32

// total capacity in bytes
// banks times lines times words times four bytes
`define SHM_SIZE_BYTES (`SHM_NUM_BANKS * `SHM_BANK_HEIGHT * `SHM_WORDS_PER_LINE * 4)

`endif

/* common/shm_pkg.sv */
`include "shm_config.svh"

package shm_pkg;

	// field widths derived from the config
	localparam int SHM_BANK_BITS = $clog2(`SHM_NUM_BANKS);
	localparam int SHM_ROW_BITS = $clog2(`SHM_BANK_HEIGHT);
	localparam int SHM_WORD_BITS = $clog2(`SHM_WORDS_PER_LINE);
	// whatever is left above the row field
	localparam int SHM_UPPER_BITS =
		`SHM_ADDR_WIDTH - 2 - SHM_WORD_BITS - SHM_BANK_BITS - SHM_ROW_BITS;

	// address split for routing, low order fields last
	// word bits sit below bank bits, so consecutive lines interleave banks
	typedef struct packed {
		logic [SHM_UPPER_BITS-1:0] upper;
		logic [SHM_ROW_BITS-1:0] row;
		logic [SHM_BANK_BITS-1:0] bank;
		logic [SHM_WORD_BITS-1:0] word;
		logic [1:0] byte_off;
	} shm_addr_fields_t;

	// flat view for the range check, field view for routing
	typedef union packed {
		logic [`SHM_ADDR_WIDTH-1:0] flat;
		shm_addr_fields_t fields;
	} shm_addr_u;

	// request from the single requester
	typedef struct packed {
		logic write;
		shm_addr_u addr;
		logic [31:0] wdata;
		logic [3:0] be;
	} shm_req_t;

	// per-bank access, at most one enabled per cycle
	typedef struct packed {
		logic en;
		logic write;
		logic [SHM_ROW_BITS-1:0] row;
		logic [SHM_WORD_BITS-1:0] word;
		logic [31:0] wdata;
		logic [3:0] be;
	} shm_bank_req_t;

	// response status codes
	typedef enum logic [1:0] {
		OK = 2'd0,
		RANGE_ERR = 2'd1,
		ALIGN_ERR = 2'd2
	} shm_status_e;

	// routing info carried alongside the bank access
	typedef struct packed {
		logic valid;
		logic write;
		logic [SHM_BANK_BITS-1:0] bank;
		logic [SHM_WORD_BITS-1:0] word;
		shm_status_e status;
	} shm_tag_t;

	// response back to the requester
	typedef struct packed {
		logic [31:0] rdata;
		shm_status_e status;
		logic write;
	} shm_rsp_t;

endpackage

/* smem/shm_bank_block.sv */
`include "shm_config.svh"

// one bank, line-wide storage with single word writes
module shm_bank_block import shm_pkg::*; (
	input logic clk,
	input logic reset,
	input shm_bank_req_t bank_req,
	output logic [`SHM_WORDS_PER_LINE-1:0][31:0] line
);

	// storage array, words split into bytes for the write mask
	logic [`SHM_WORDS_PER_LINE-1:0][3:0][7:0] mem [`SHM_BANK_HEIGHT];

	// write port
	// only the addressed word is touched
	// and within it only the enabled bytes
	always_ff @(posedge clk) begin
		if (bank_req.en && bank_req.write) begin
			for (int b = 0; b < 4; b++) begin
				if (bank_req.be[b]) begin
					mem[bank_req.row][bank_req.word][b] <= bank_req.wdata[b*8 +: 8];
				end
			end
		end
	end

	// read port, whole line registered at the same edge
	// a write in this cycle is not yet visible here
	// reads one cycle later see it
	// line holds while the bank is idle to avoid toggling
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			line <= '0;
		end else if (bank_req.en) begin
			line <= mem[bank_req.row];
		end
	end

endmodule

/* smem/shm_req_router.sv */
`include "shm_config.svh"

// address decode and steering to the banks
// purely combinational, same cycle as the request
module shm_req_router import shm_pkg::*; (
	input logic req_valid,
	input shm_req_t req,
	output shm_bank_req_t [`SHM_NUM_BANKS-1:0] bank_req,
	output shm_tag_t tag
);

	logic range_err;
	logic align_err;
	shm_status_e status;

	// range check on the flat view
	// upper address bits are covered by this compare
	assign range_err = req.addr.flat >= `SHM_ADDR_WIDTH'(`SHM_SIZE_BYTES);

	// word accesses only, any low byte bit is misaligned
	assign align_err = |req.addr.fields.byte_off;

	// range error wins over alignment
	always_comb begin
		if (range_err) begin
			status = RANGE_ERR;
		end else if (align_err) begin
			status = ALIGN_ERR;
		end else begin
			status = OK;
		end
	end

	// tag for the collector
	// errors still get a tag so every request gets a response
	always_comb begin
		tag.valid = req_valid;
		tag.write = req.write;
		tag.bank = req.addr.fields.bank;
		tag.word = req.addr.fields.word;
		tag.status = status;
	end

	// fan out to the banks
	// payload goes to every bank, only the enable is decoded
	// no bank enabled for an erroneous request
	always_comb begin
		for (int i = 0; i < `SHM_NUM_BANKS; i++) begin
			bank_req[i].en = req_valid && (status == OK) &&
				(req.addr.fields.bank == SHM_BANK_BITS'(i));
			bank_req[i].write = req.write;
			bank_req[i].row = req.addr.fields.row;
			bank_req[i].word = req.addr.fields.word;
			bank_req[i].wdata = req.wdata;
			bank_req[i].be = req.be;
		end
	end

endmodule

/* smem/shm_rsp_collector.sv */
`include "shm_config.svh"

// response path, two register stages
// stage 1 aligns the tag with the registered bank lines
// stage 2 holds the selected word and status
module shm_rsp_collector import shm_pkg::*; (
	input logic clk,
	input logic reset,
	input shm_tag_t tag,
	input logic [`SHM_NUM_BANKS-1:0][`SHM_WORDS_PER_LINE-1:0][31:0] lines,
	output logic rsp_valid,
	output shm_rsp_t rsp
);

	shm_tag_t tag_q;
	logic [31:0] word_sel;
	logic [31:0] rdata;

	// stage 1, tag delayed to match the bank read latency
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tag_q <= '0;
		end else begin
			tag_q <= tag;
		end
	end

	// pick the answering bank and the word within its line
	// lines of idle banks are stale but never selected
	assign word_sel = lines[tag_q.bank][tag_q.word];

	// data only for a clean read
	// writes and errors return zero
	always_comb begin
		if (!tag_q.write && (tag_q.status == OK)) begin
			rdata = word_sel;
		end else begin
			rdata = '0;
		end
	end

	// stage 2, response strobe
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= tag_q.valid;
		end
	end

	// stage 2, response payload
	// only loaded for a live tag, holds otherwise
	always_ff @(posedge clk) begin
		if (tag_q.valid) begin
			rsp.rdata <= rdata;
			rsp.status <= tag_q.status;
			rsp.write <= tag_q.write;
		end
	end

endmodule

/* rtl/shared_memory.sv */
`include "shm_config.svh"

// banked scratchpad, one requester
// response two cycles after each request, in order
module shared_memory import shm_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input shm_req_t req,
	output logic rsp_valid,
	output shm_rsp_t rsp
);

	// router outputs
	shm_bank_req_t [`SHM_NUM_BANKS-1:0] bank_req;
	shm_tag_t tag;

	// registered lines, one per bank
	logic [`SHM_NUM_BANKS-1:0][`SHM_WORDS_PER_LINE-1:0][31:0] bank_lines;

	// decode and steer
	shm_req_router u_router (
		.req_valid(req_valid),
		.req(req),
		.bank_req(bank_req),
		.tag(tag)
	);

	// identical banks
	// each sees only its own request slice
	for (genvar i = 0; i < `SHM_NUM_BANKS; i++) begin : g_bank
		shm_bank_block u_bank (
			.clk(clk),
			.reset(reset),
			.bank_req(bank_req[i]),
			.line(bank_lines[i])
		);
	end

	// select and register the response
	shm_rsp_collector u_collector (
		.clk(clk),
		.reset(reset),
		.tag(tag),
		.lines(bank_lines),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

endmodule

/* verif/shared_memory_tb.sv */
`include "shm_config.svh"

// testbench for the banked shared memory
// shadow byte model with an expected queue and assertion checks
module shared_memory_tb import shm_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SIZE = `SHM_SIZE_BYTES;
	localparam int N_WORDS = SIZE / 4;
	localparam int IDX_W = $clog2(SIZE);
	localparam int RESET_CYCLES = 5;
	localparam int N_PART = 24;
	// two rows of every bank and word
	localparam int N_SWEEP = 2 * `SHM_NUM_BANKS * `SHM_WORDS_PER_LINE;
	localparam int N_RAND = 400;
	// reset, idle, fill, directed, partial, sweep, random worst case, errors, drain
	localparam int STIM_CYCLES = RESET_CYCLES + 3 + N_WORDS + 7 + 2 * N_PART + N_SWEEP +
		2 * N_RAND + 9 + 4;
	localparam int CYCLE_LIMIT = STIM_CYCLES + 20;

	logic clk;
	logic reset;
	logic req_valid;
	shm_req_t req;
	logic rsp_valid;
	shm_rsp_t rsp;

	// shadow of the whole memory, one entry per byte
	logic [7:0] shadow [SIZE];
	shm_rsp_t exp_q [$];
	// response expected in the current cycle and what the DUT showed
	shm_rsp_t exp_now;
	shm_rsp_t rsp_seen;
	int errors;
	int checked;
	int cycles;

	shared_memory dut (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// fill value built from the low 16 address bits, which span the whole memory
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {~addr[15:0], addr[15:0]} ^ 32'hA5C3_0000;
	endfunction

	// byte address of sweep step i
	// bank changes fastest, then word, then row
	function automatic logic [31:0] sweep_addr(input int i);
		int bank;
		int word;
		int row;
		bank = i % `SHM_NUM_BANKS;
		word = (i / `SHM_NUM_BANKS) % `SHM_WORDS_PER_LINE;
		row = i / (`SHM_NUM_BANKS * `SHM_WORDS_PER_LINE);
		return 32'(((row * `SHM_NUM_BANKS + bank) * `SHM_WORDS_PER_LINE + word) * 4);
	endfunction

	// one request this cycle with its expected response queued and the shadow updated
	task automatic send(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] be);
		shm_rsp_t exp;
		logic [IDX_W-3:0] w;
		logic [31:0] mask;
		logic [31:0] old;
		logic [31:0] upd;
		w = addr[IDX_W-1:2];
		old = {shadow[{w, 2'd3}], shadow[{w, 2'd2}], shadow[{w, 2'd1}], shadow[{w, 2'd0}]};
		exp.write = write;
		exp.rdata = 32'h0;
		if (addr >= SIZE) begin
			exp.status = RANGE_ERR;
		end else if (addr[1:0] != 2'b00) begin
			exp.status = ALIGN_ERR;
		end else begin
			exp.status = OK;
			if (write) begin
				// byte lane n of the word is wdata bits 8n+7..8n
				mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
				upd = (old & ~mask) | (wdata & mask);
				shadow[{w, 2'd0}] = upd[7:0];
				shadow[{w, 2'd1}] = upd[15:8];
				shadow[{w, 2'd2}] = upd[23:16];
				shadow[{w, 2'd3}] = upd[31:24];
			end else begin
				exp.rdata = old;
			end
		end
		exp_q.push_back(exp);
		req_valid = 1'b1;
		req.write = write;
		req.addr.flat = addr;
		req.wdata = wdata;
		req.be = be;
		@(posedge clk);
		#10;
		req_valid = 1'b0;
	endtask

	// no request for n cycles
	task automatic idle(input int n);
		req_valid = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#10;
		end
	endtask

	// response of this cycle lined up for the check at the next edge
	always @(negedge clk) begin
		if (rsp_valid === 1'b1) begin
			rsp_seen = rsp;
			if (exp_q.size() == 0) begin
				errors++;
				$display("response at %0t came with no request outstanding", $time);
			end else begin
				exp_now = exp_q.pop_front();
				checked++;
			end
		end
	end

	// strobe exactly two cycles behind each request
	a_rsp_timing: assert property (@(posedge clk) disable iff (reset)
		rsp_valid == $past(req_valid, 2))
	else begin
		errors++;
		$display("[ERROR] %0t: rsp_valid out of step with req_valid", $time);
	end

	// data, status and write flag against the shadow model
	a_rsp_value: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |-> (rsp == exp_now))
	else begin
		errors++;
		$display("[ERROR] %0t: expected data %h status %0d write %0b, got %h %0d %0b",
			$time, exp_now.rdata, exp_now.status, exp_now.write,
			rsp_seen.rdata, rsp_seen.status, rsp_seen.write);
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout, run went past %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		logic [31:0] addr;
		logic [31:0] r;
		void'($urandom(97125));
		errors = 0;
		checked = 0;
		cycles = 0;
		exp_now = '0;
		rsp_seen = '0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		reset = 1'b0;
		// quiet after reset so rsp_valid must stay low
		idle(3);
		// fill every word back to back and check the write responses
		for (int i = 0; i < N_WORDS; i++) begin
			addr = i * 4;
			send(1'b1, addr, fill_word(addr), 4'hF);
		end
		// write then read in the very next cycle and again later
		send(1'b1, 32'h100, 32'hDEAD_BEEF, 4'hF);
		send(1'b0, 32'h100, 32'h0, 4'h0);
		idle(2);
		send(1'b0, 32'h100, 32'h0, 4'h0);
		send(1'b1, 32'h1F0, 32'h1234_5678, 4'hF);
		send(1'b0, 32'h1F0, 32'h0, 4'h0);
		// byte enable subsets
		for (int i = 0; i < N_PART; i++) begin
			addr = ($urandom % N_WORDS) * 4;
			r = $urandom;
			send(1'b1, addr, $urandom, r[3:0]);
			send(1'b0, addr, 32'h0, 4'h0);
		end
		// every bank and word with a new bank each cycle
		for (int i = 0; i < N_SWEEP; i++) begin
			send(1'b0, sweep_addr(i), 32'h0, 4'h0);
		end
		// random mix with occasional gaps
		for (int i = 0; i < N_RAND; i++) begin
			addr = ($urandom % N_WORDS) * 4;
			r = $urandom;
			if (r[4]) begin
				send(1'b1, addr, $urandom, r[3:0]);
			end else begin
				send(1'b0, addr, 32'h0, 4'h0);
			end
			if (r[6:5] == 2'b00) begin
				idle(1);
			end
		end
		// out of range then misaligned requests that must leave memory alone
		send(1'b0, SIZE, 32'h0, 4'h0);
		send(1'b1, SIZE, 32'hBAD0_0001, 4'hF);
		send(1'b1, 32'hFFFF_FFFC, 32'hBAD0_0002, 4'hF);
		send(1'b0, 32'h201, 32'h0, 4'h0);
		send(1'b1, 32'h202, 32'hBAD0_0003, 4'hF);
		send(1'b1, 32'h203, 32'hBAD0_0004, 4'hF);
		// aliases of the bad addresses still hold the old data
		send(1'b0, 32'h0, 32'h0, 4'h0);
		send(1'b0, SIZE - 4, 32'h0, 4'h0);
		send(1'b0, 32'h200, 32'h0, 4'h0);
		idle(4);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d requests never got a response", exp_q.size());
		end
		$display("responses checked: %0d, errors: %0d", checked, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* shared_memory.f */
+incdir+common
common/shm_pkg.sv
smem/shm_bank_block.sv
smem/shm_req_router.sv
smem/shm_rsp_collector.sv
rtl/shared_memory.sv
verif/shared_memory_tb.sv

/* Makefile */
# Verilator build for the shared memory testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP ?= shared_memory_tb
FILELIST ?= shared_memory.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Everything OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
